//--- common/bus_pkg.sv
package bus_pkg;

   localparam int BUS_W = 32; // Host data bus width.

   // Word offsets inside the control region.
   typedef enum logic [1:0] {
      REG_OP    = 2'd0, // Combine operation, read/write.
      REG_COUNT = 2'd1, // Result count, read only.
      REG_CLEAR = 2'd2  // Any write zeroes the count.
   } ctrl_reg_e;

   localparam logic REGION_CTRL = 1'b1; // Top address bit; 0 selects the table.

   function automatic logic is_write(input logic [BUS_W/8-1:0] strb);
      return |strb;
   endfunction

   function automatic logic in_ctrl(input logic region_bit);
      return region_bit == REGION_CTRL;
   endfunction

   // Address bits [3:2] name the register.
   function automatic ctrl_reg_e ctrl_word(input logic [1:0] word_bits);
      return ctrl_reg_e'(word_bits);
   endfunction

endpackage

//--- common/datapath_pkg.sv
package datapath_pkg;

   // How the two lane words are merged.
   typedef enum logic [1:0] {
      OP_LANE0 = 2'd0, // Pass lane 0.
      OP_ADD   = 2'd1, // Wrapping sum.
      OP_SUB   = 2'd2, // Lane 0 minus lane 1, wrapping.
      OP_MAX   = 2'd3  // Unsigned maximum.
   } combine_op_e;

   localparam combine_op_e OP_RESET = OP_LANE0;

endpackage

//--- hw/lookup_table/dual_port_ram.sv
`timescale 1ns/10ps

module dual_port_ram #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  logic              clk,
   input  logic              a_en,
   input  logic              a_we,
   input  logic [ADDR_W-1:0] a_addr,
   input  logic [DATA_W-1:0] a_wdata,
   input  logic              b_en,
   input  logic [ADDR_W-1:0] b_addr,
   output logic [DATA_W-1:0] a_rdata,
   output logic [DATA_W-1:0] b_rdata
);

   localparam int DEPTH = 2**(ADDR_W-2);

   logic [DATA_W-1:0] mem [0:DEPTH-1];

   logic [ADDR_W-3:0] a_idx;
   logic [ADDR_W-3:0] b_idx;

   // Byte address to word index.
   assign a_idx = a_addr[ADDR_W-1:2];
   assign b_idx = b_addr[ADDR_W-1:2];

   // ====================
   // Port a, read/write
   // ====================
   always_ff @(posedge clk) begin
      if (a_en) begin
         if (a_we) begin
            mem[a_idx] <= a_wdata;
         end
         a_rdata <= mem[a_idx]; // Old contents on a write.
      end
   end

   // ====================
   // Port b, read only
   // ====================
   always_ff @(posedge clk) begin
      if (b_en) begin
         b_rdata <= mem[b_idx];
      end
   end

endmodule

//--- hw/lookup_table/lookup_table.sv
`timescale 1ns/10ps

module lookup_table #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              tbl_wr,
   input  logic [ADDR_W-1:0] tbl_addr,
   input  logic [DATA_W-1:0] tbl_data,
   input  logic              in_valid,
   input  logic [DATA_W-1:0] in0,
   input  logic [DATA_W-1:0] in1,
   output logic              lane_valid,
   output logic [DATA_W-1:0] lane0,
   output logic [DATA_W-1:0] lane1
);

   logic              wr_pend;
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;

   logic [ADDR_W-1:0] a_addr;
   logic [ADDR_W-1:0] b_addr;
   logic [DATA_W-1:0] a_rdata;
   logic [DATA_W-1:0] b_rdata;

   logic [1:0] vld_pipe;

   // ====================
   // Table write staging
   // ====================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_pend <= 1'b0;
      end else begin
         wr_pend <= tbl_wr;
      end
   end

   always_ff @(posedge clk) begin
      if (tbl_wr) begin
         wr_addr <= tbl_addr;
         wr_data <= tbl_data;
      end
   end

   // A pending write takes port a away from lane 0.
   assign a_addr = wr_pend ? wr_addr : {in0[ADDR_W-3:0], 2'b00};
   assign b_addr = {in1[ADDR_W-3:0], 2'b00};

   dual_port_ram #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_ram (
      .clk     (clk),
      .a_en    (wr_pend | in_valid),
      .a_we    (wr_pend),
      .a_addr  (a_addr),
      .a_wdata (wr_data),
      .b_en    (in_valid),
      .b_addr  (b_addr),
      .a_rdata (a_rdata),
      .b_rdata (b_rdata)
   );

   // ====================
   // Output stage
   // ====================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld_pipe <= 2'b00;
      end else begin
         vld_pipe <= {vld_pipe[0], in_valid}; // Read, then output register.
      end
   end

   always_ff @(posedge clk) begin
      lane0 <= a_rdata;
      lane1 <= b_rdata;
   end

   assign lane_valid = vld_pipe[1];

endmodule

//--- hw/ctrl_regs.sv
`timescale 1ns/10ps

module ctrl_regs
   import bus_pkg::*, datapath_pkg::*;
#(
   parameter int ADDR_W = 8
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               valid,
   input  logic [ADDR_W:0]    addr,
   input  logic [BUS_W-1:0]   wdata,
   input  logic [BUS_W/8-1:0] wstrb,
   input  logic               out_valid,
   output logic               ready,
   output logic [BUS_W-1:0]   rdata,
   output logic               tbl_wr,
   output logic [ADDR_W-1:0]  tbl_addr,
   output logic [BUS_W-1:0]   tbl_data,
   output combine_op_e        op
);

   logic       wr;
   logic       ctrl_sel;
   ctrl_reg_e  word;
   logic       op_wr;
   logic       clr_wr;
   logic [31:0] count;
   logic [BUS_W-1:0] rdata_next;

   // ====================
   // Decode
   // ====================
   assign wr       = valid && is_write(wstrb);
   assign ctrl_sel = in_ctrl(addr[ADDR_W]);
   assign word     = ctrl_word(addr[3:2]);

   assign op_wr  = wr && ctrl_sel && (word == REG_OP);
   assign clr_wr = wr && ctrl_sel && (word == REG_CLEAR);

   // Table writes pass straight through.
   assign tbl_wr   = wr && !ctrl_sel;
   assign tbl_addr = addr[ADDR_W-1:0];
   assign tbl_data = wdata;

   // ====================
   // Registers
   // ====================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op    <= OP_RESET;
         count <= '0;
         ready <= 1'b0;
      end else begin
         ready <= valid; // One cycle after every access.
         if (op_wr) begin
            op <= combine_op_e'(wdata[1:0]);
         end
         if (clr_wr) begin
            count <= '0; // Clear beats increment.
         end else if (out_valid) begin
            count <= count + 32'd1;
         end
      end
   end

   // Table region reads back zero.
   always_comb begin
      rdata_next = '0;
      if (ctrl_sel) begin
         case (word)
            REG_OP:    rdata_next = BUS_W'(op);
            REG_COUNT: rdata_next = count;
            default:   rdata_next = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (valid) begin
         rdata <= rdata_next;
      end
   end

endmodule

//--- hw/lane_combine.sv
`timescale 1ns/10ps

module lane_combine
   import datapath_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  combine_op_e       op,
   input  logic              lane_valid,
   input  logic [DATA_W-1:0] lane0,
   input  logic [DATA_W-1:0] lane1,
   output logic              out_valid,
   output logic [DATA_W-1:0] result
);

   logic [DATA_W-1:0] comb_out;

   // ====================
   // Combine
   // ====================
   always_comb begin
      case (op)
         OP_LANE0: comb_out = lane0;
         OP_ADD:   comb_out = lane0 + lane1; // Wraps.
         OP_SUB:   comb_out = lane0 - lane1;
         OP_MAX:   comb_out = (lane0 > lane1) ? lane0 : lane1;
         default:  comb_out = lane0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= lane_valid;
      end
   end

   // Holds the last result between samples.
   always_ff @(posedge clk) begin
      if (lane_valid) begin
         result <= comb_out;
      end
   end

endmodule

//--- hw/lut_engine.sv
`timescale 1ns/10ps

module lut_engine
   import bus_pkg::*, datapath_pkg::*;
#(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  logic               clk,
   input  logic               rst,
   // Host bus.
   input  logic               valid,
   input  logic [ADDR_W:0]    addr,
   input  logic [BUS_W-1:0]   wdata,
   input  logic [BUS_W/8-1:0] wstrb,
   output logic               ready,
   output logic [BUS_W-1:0]   rdata,
   // Sample stream.
   input  logic               in_valid,
   input  logic [DATA_W-1:0]  in0,
   input  logic [DATA_W-1:0]  in1,
   output logic               out_valid,
   output logic [DATA_W-1:0]  result
);

   logic              tbl_wr;
   logic [ADDR_W-1:0] tbl_addr;
   logic [BUS_W-1:0]  tbl_data;
   combine_op_e       op;

   logic              lane_valid;
   logic [DATA_W-1:0] lane0;
   logic [DATA_W-1:0] lane1;

   // ====================
   // Host side
   // ====================
   ctrl_regs #(
      .ADDR_W (ADDR_W)
   ) u_ctrl_regs (
      .clk       (clk),
      .rst       (rst),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .out_valid (out_valid),
      .ready     (ready),
      .rdata     (rdata),
      .tbl_wr    (tbl_wr),
      .tbl_addr  (tbl_addr),
      .tbl_data  (tbl_data),
      .op        (op)
   );

   // ====================
   // Stream side
   // ====================
   lookup_table #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_lookup_table (
      .clk        (clk),
      .rst        (rst),
      .tbl_wr     (tbl_wr),
      .tbl_addr   (tbl_addr),
      .tbl_data   (tbl_data),
      .in_valid   (in_valid),
      .in0        (in0),
      .in1        (in1),
      .lane_valid (lane_valid),
      .lane0      (lane0),
      .lane1      (lane1)
   );

   lane_combine #(
      .DATA_W (DATA_W)
   ) u_lane_combine (
      .clk        (clk),
      .rst        (rst),
      .op         (op),
      .lane_valid (lane_valid),
      .lane0      (lane0),
      .lane1      (lane1),
      .out_valid  (out_valid),
      .result     (result)
   );

endmodule

//--- verification/lut_engine_tb.sv
`timescale 1ns/10ps

module lut_engine_tb
   import bus_pkg::*, datapath_pkg::*;
();

   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 8;
   localparam int ENTRIES    = 2**(ADDR_W-2);
   localparam int MAX_CYCLES = 2000; // Roughly four times the stimulus.

   logic               clk = 1'b0;
   logic               rst;
   logic               valid;
   logic [ADDR_W:0]    addr;
   logic [BUS_W-1:0]   wdata;
   logic [BUS_W/8-1:0] wstrb;
   logic               ready;
   logic [BUS_W-1:0]   rdata;
   logic               in_valid;
   logic [DATA_W-1:0]  in0;
   logic [DATA_W-1:0]  in1;
   logic               out_valid;
   logic [DATA_W-1:0]  result;

   // Reference model.
   logic [DATA_W-1:0] table_model [0:ENTRIES-1];
   combine_op_e       cur_op;
   integer            seed;
   logic              started;
   int                count_base;

   // Expected results and read data in arrival order.
   logic [DATA_W-1:0] exp_res_mem [0:1023];
   logic [BUS_W-1:0]  exp_rd_mem [0:63];
   int                res_wr;
   int                rd_wr;

   int                res_rd;
   int                rd_rd;
   int                pulse_count;
   logic              last_rd;
   logic              res_chk;
   logic              rd_chk;
   logic [DATA_W-1:0] got_res;
   logic [DATA_W-1:0] exp_res;
   logic [BUS_W-1:0]  got_rd;
   logic [BUS_W-1:0]  exp_rd;
   int                cycle_count = 0;

   lut_engine DUT (
      .clk       (clk),
      .rst       (rst),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .ready     (ready),
      .rdata     (rdata),
      .in_valid  (in_valid),
      .in0       (in0),
      .in1       (in1),
      .out_valid (out_valid),
      .result    (result)
   );

   always #5 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      $display("Test FAILED");
      $fatal(1, "Stopping on first error");
   endtask

   // ====================
   // Monitor
   // ====================
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         res_rd      <= 0;
         rd_rd       <= 0;
         pulse_count <= 0;
         last_rd     <= 1'b0;
         res_chk     <= 1'b0;
         rd_chk      <= 1'b0;
      end else begin
         res_chk <= 1'b0;
         rd_chk  <= 1'b0;
         last_rd <= valid && (wstrb == '0);
         if (out_valid) begin
            got_res     <= result;
            exp_res     <= exp_res_mem[res_rd];
            res_rd      <= res_rd + 1;
            pulse_count <= pulse_count + 1;
            res_chk     <= 1'b1;
         end
         if (ready && last_rd) begin // Read data rides with ready.
            got_rd <= rdata;
            exp_rd <= exp_rd_mem[rd_rd];
            rd_rd  <= rd_rd + 1;
            rd_chk <= 1'b1;
         end
      end
   end

   // ====================
   // Checks
   // ====================
   idle_check: assert property (@(posedge clk) !started |-> (!ready && !out_valid))
      else report_failure("ready or out_valid active before stimulus");

   ready_check: assert property (@(posedge clk) disable iff (rst) ready == $past(valid))
      else report_failure("ready not exactly one cycle after valid");

   latency_check: assert property (@(posedge clk) disable iff (rst)
      out_valid == $past(in_valid, 3))
      else report_failure("out_valid not exactly three cycles after in_valid");

   result_check: assert property (@(posedge clk) res_chk |-> got_res == exp_res)
      else report_failure($sformatf("result %h, expected %h",
         $sampled(got_res), $sampled(exp_res)));

   rdata_check: assert property (@(posedge clk) rd_chk |-> got_rd == exp_rd)
      else report_failure($sformatf("rdata %h, expected %h",
         $sampled(got_rd), $sampled(exp_rd)));

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test FAILED");
         $fatal(1, "Timeout");
      end
   end

   // ====================
   // Stimulus helpers
   // ====================
   function automatic logic [ADDR_W:0] ctrl_addr(input ctrl_reg_e r);
      return {REGION_CTRL, {(ADDR_W-4){1'b0}}, 2'(r), 2'b00};
   endfunction

   function automatic logic [ADDR_W:0] table_addr(input int idx);
      return {~REGION_CTRL, idx[ADDR_W-3:0], 2'b00};
   endfunction

   function automatic logic [DATA_W-1:0] expected_result(input combine_op_e o,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
      case (o)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_MAX:  return (a >= b) ? a : b;
         default: return a;
      endcase
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic bus_access(input logic [ADDR_W:0] a, input logic [BUS_W-1:0] d,
      input logic [BUS_W/8-1:0] s);
      valid = 1'b1;
      addr  = a;
      wdata = d;
      wstrb = s;
      next_cycle();
      valid = 1'b0;
      wstrb = '0;
   endtask

   task automatic bus_read(input logic [ADDR_W:0] a, input logic [BUS_W-1:0] expected);
      exp_rd_mem[rd_wr] = expected;
      rd_wr = rd_wr + 1;
      bus_access(a, '0, '0);
   endtask

   task automatic set_op(input combine_op_e o);
      bus_access(ctrl_addr(REG_OP), BUS_W'(o), 4'hf);
      cur_op = o;
      bus_read(ctrl_addr(REG_OP), BUS_W'(o));
   endtask

   task automatic send_pair(input logic [DATA_W-1:0] s0, input logic [DATA_W-1:0] s1);
      exp_res_mem[res_wr] = expected_result(cur_op, table_model[s0[ADDR_W-3:0]],
         table_model[s1[ADDR_W-3:0]]);
      res_wr   = res_wr + 1;
      in_valid = 1'b1;
      in0      = s0;
      in1      = s1;
      next_cycle();
      in_valid = 1'b0;
   endtask

   task automatic stream_random(input int n);
      logic [DATA_W-1:0] s0;
      logic [DATA_W-1:0] s1;
      repeat (n) begin
         s0 = $random(seed);
         s1 = $random(seed);
         send_pair(s0, s1);
      end
   endtask

   task automatic wait_drain();
      while (res_rd != res_wr) next_cycle();
   endtask

   task automatic rewrite_entry(input int idx, input logic [BUS_W/8-1:0] s);
      table_model[idx] = $random(seed); // Any nonzero strobe writes the whole word.
      bus_access(table_addr(idx), table_model[idx], s);
      idle_cycles(1);
   endtask

   // ====================
   // Test sequence
   // ====================
   initial begin
      rst = 1'b1;
      valid = 1'b0;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      in_valid = 1'b0;
      in0 = '0;
      in1 = '0;
      seed = 32'h1113;
      started = 1'b0;
      cur_op = OP_LANE0;
      count_base = 0;
      res_wr = 0;
      rd_wr = 0;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;
      idle_cycles(2);
      started = 1'b1;

      bus_read(ctrl_addr(REG_OP), BUS_W'(OP_LANE0));
      bus_read(ctrl_addr(REG_COUNT), '0);
      bus_read(table_addr(5), '0); // Table reads return zero.

      for (int i = 0; i < ENTRIES; i++) begin
         table_model[i] = $random(seed);
         bus_access(table_addr(i), table_model[i], 4'hf);
      end
      idle_cycles(1);
      stream_random(100);
      wait_drain();
      bus_read(ctrl_addr(REG_COUNT), BUS_W'(pulse_count - count_base));

      set_op(OP_ADD);
      stream_random(30);
      wait_drain();
      set_op(OP_SUB);
      stream_random(30);
      wait_drain();
      set_op(OP_MAX);
      stream_random(30);
      wait_drain();

      bus_read(ctrl_addr(REG_COUNT), BUS_W'(pulse_count - count_base));
      bus_access(ctrl_addr(REG_CLEAR), 32'h1, 4'hf);
      count_base = pulse_count;
      bus_read(ctrl_addr(REG_COUNT), '0);
      stream_random(10);
      wait_drain();
      bus_read(ctrl_addr(REG_COUNT), BUS_W'(pulse_count - count_base));

      // Rewritten entry seen two cycles after the write strobe.
      set_op(OP_LANE0);
      rewrite_entry(17, 4'hf);
      send_pair(32'd17, 32'h0000_0111);
      wait_drain();
      set_op(OP_ADD);
      rewrite_entry(42, 4'b0010);
      send_pair(32'd42, 32'hfff0_00ea); // Same entry on both lanes.
      wait_drain();
      idle_cycles(3);

      if (res_rd == res_wr && rd_rd == rd_wr) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("Expected results or read data never arrived");
         $display("Test FAILED");
         $fatal(1, "Missing responses");
      end
   end

endmodule

//--- lut_engine.f
common/bus_pkg.sv
common/datapath_pkg.sv
hw/lookup_table/dual_port_ram.sv
hw/lookup_table/lookup_table.sv
hw/ctrl_regs.sv
hw/lane_combine.sv
hw/lut_engine.sv
verification/lut_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the lut_engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
      --top-module lut_engine_tb \
      -f lut_engine.f \
      -o lut_engine_sim; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/lut_engine_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
   exit 0
else
   echo "Pass message not found"
   exit 1
fi
